// File: verilog/axi_pkg.sv
// AXI bridge shared definitions
package axi_pkg;

  // Address and data widths are the same on the AXI4 and the AXI4-Lite side
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // One strobe bit per data byte
  localparam int STRB_W = DATA_W / 8;

  // Transaction ID and user sideband widths exist on the AXI4 side only
  localparam int ID_W   = 4;
  localparam int USER_W = 2;

  // Response codes used by the register file
  // EXOKAY and DECERR never occur in this design
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_t;

  // Per-transaction metadata that the AXI4-Lite side cannot carry
  // The bridge stores it on the request and returns it with the response
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [USER_W-1:0] user;
  } meta_t;

endpackage

// File: verilog/axi4_if.sv
// AXI4 single-beat bus
`timescale 1ns/1ns

interface axi4_if import axi_pkg::*; ();

  // Write address channel
  logic [ID_W-1:0]   aw_id;
  logic [ADDR_W-1:0] aw_addr;
  logic [USER_W-1:0] aw_user;
  logic              aw_valid;
  logic              aw_ready;

  // Write data channel with one beat per transaction
  logic [DATA_W-1:0] w_data;
  logic [STRB_W-1:0] w_strb;
  logic              w_valid;
  logic              w_ready;

  // Write response channel
  logic [ID_W-1:0]   b_id;
  resp_t             b_resp;
  logic [USER_W-1:0] b_user;
  logic              b_valid;
  logic              b_ready;

  // Read address channel
  logic [ID_W-1:0]   ar_id;
  logic [ADDR_W-1:0] ar_addr;
  logic [USER_W-1:0] ar_user;
  logic              ar_valid;
  logic              ar_ready;

  // Read data channel
  // r_last is kept for compatibility although every read is a single beat
  logic [ID_W-1:0]   r_id;
  logic [DATA_W-1:0] r_data;
  resp_t             r_resp;
  logic              r_last;
  logic [USER_W-1:0] r_user;
  logic              r_valid;
  logic              r_ready;

  modport master (
    output aw_id, aw_addr, aw_user, aw_valid, input aw_ready,
    output w_data, w_strb, w_valid, input w_ready,
    input b_id, b_resp, b_user, b_valid, output b_ready,
    output ar_id, ar_addr, ar_user, ar_valid, input ar_ready,
    input r_id, r_data, r_resp, r_last, r_user, r_valid, output r_ready
  );

  modport slave (
    input aw_id, aw_addr, aw_user, aw_valid, output aw_ready,
    input w_data, w_strb, w_valid, output w_ready,
    output b_id, b_resp, b_user, b_valid, input b_ready,
    input ar_id, ar_addr, ar_user, ar_valid, output ar_ready,
    output r_id, r_data, r_resp, r_last, r_user, r_valid, input r_ready
  );

endinterface

// File: verilog/axi_lite_if.sv
// AXI4-Lite bus
`timescale 1ns/1ns

interface axi_lite_if import axi_pkg::*; ();

  // Write address channel
  logic [ADDR_W-1:0] aw_addr;
  logic              aw_valid;
  logic              aw_ready;

  // Write data channel
  logic [DATA_W-1:0] w_data;
  logic [STRB_W-1:0] w_strb;
  logic              w_valid;
  logic              w_ready;

  // Write response channel
  resp_t             b_resp;
  logic              b_valid;
  logic              b_ready;

  // Read address channel
  logic [ADDR_W-1:0] ar_addr;
  logic              ar_valid;
  logic              ar_ready;

  // Read data channel
  logic [DATA_W-1:0] r_data;
  resp_t             r_resp;
  logic              r_valid;
  logic              r_ready;

  modport master (
    output aw_addr, aw_valid, input aw_ready,
    output w_data, w_strb, w_valid, input w_ready,
    input b_resp, b_valid, output b_ready,
    output ar_addr, ar_valid, input ar_ready,
    input r_data, r_resp, r_valid, output r_ready
  );

  modport slave (
    input aw_addr, aw_valid, output aw_ready,
    input w_data, w_strb, w_valid, output w_ready,
    output b_resp, b_valid, input b_ready,
    input ar_addr, ar_valid, output ar_ready,
    output r_data, r_resp, r_valid, input r_ready
  );

endinterface

// File: verilog/id_fifo.sv
// In-order metadata FIFO
`timescale 1ns/1ns

module id_fifo import axi_pkg::*; #(
  parameter type dtype = meta_t,
  // Must be a power of two and at least 2
  parameter int  DEPTH = 2
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic push_i,
  input  dtype data_i,
  input  logic pop_i,
  output dtype data_o,
  output logic full_o,
  output logic empty_o
);

  localparam int IDX_W = $clog2(DEPTH);

  // Storage for the queued entries
  dtype mem [DEPTH];

  // Pointers carry one extra wrap bit above the index bits
  logic [IDX_W:0] wr_ptr_q;
  logic [IDX_W:0] rd_ptr_q;

  logic do_push;
  logic do_pop;

  // Same index and same wrap bit means nothing is stored
  assign empty_o = (wr_ptr_q == rd_ptr_q);

  // Same index with a different wrap bit means every slot is taken
  assign full_o = (wr_ptr_q[IDX_W] != rd_ptr_q[IDX_W]) &&
                  (wr_ptr_q[IDX_W-1:0] == rd_ptr_q[IDX_W-1:0]);

  // Requests against a full or empty queue are ignored
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // The head entry is always visible but only meaningful while not empty
  assign data_o = mem[rd_ptr_q[IDX_W-1:0]];

  // Both pointers may move in the same cycle and keep the fill level
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Entry write at the tail slot
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q[IDX_W-1:0]] <= data_i;
    end
  end

endmodule

// File: verilog/axi_to_axi_lite.sv
// AXI4 to AXI4-Lite bridge
`timescale 1ns/1ns

module axi_to_axi_lite import axi_pkg::*; #(
  parameter int NUM_PENDING_RD = 2,
  parameter int NUM_PENDING_WR = 2
) (
  input  logic clk_i,
  input  logic rst_i,
  axi4_if.slave      slv,
  axi_lite_if.master mst
);

  // Pending counts are rounded up to a power of two and the FIFO gets at least two slots
  localparam int RD_DEPTH = (NUM_PENDING_RD > 2) ? 2 ** $clog2(NUM_PENDING_RD) : 2;
  localparam int WR_DEPTH = (NUM_PENDING_WR > 2) ? 2 ** $clog2(NUM_PENDING_WR) : 2;

  logic  rd_full;
  logic  rd_empty;
  logic  rd_push;
  logic  rd_pop;
  meta_t rd_meta_in;
  meta_t rd_meta_out;

  logic  wr_full;
  logic  wr_empty;
  logic  wr_push;
  logic  wr_pop;
  meta_t wr_meta_in;
  meta_t wr_meta_out;

  // Metadata of a read is captured when its AR beat is accepted
  assign rd_meta_in.id   = slv.ar_id;
  assign rd_meta_in.user = slv.ar_user;
  assign rd_push         = slv.ar_valid && slv.ar_ready;
  // Every read is one beat so the last beat retires the entry
  assign rd_pop          = slv.r_valid && slv.r_ready && slv.r_last;

  // Write metadata is captured on AW and retired when the B response is taken
  assign wr_meta_in.id   = slv.aw_id;
  assign wr_meta_in.user = slv.aw_user;
  assign wr_push         = slv.aw_valid && slv.aw_ready;
  assign wr_pop          = slv.b_valid && slv.b_ready;

  id_fifo #(.dtype(meta_t), .DEPTH(RD_DEPTH)) rd_meta (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (rd_push),
    .data_i  (rd_meta_in),
    .pop_i   (rd_pop),
    .data_o  (rd_meta_out),
    .full_o  (rd_full),
    .empty_o (rd_empty)
  );

  id_fifo #(.dtype(meta_t), .DEPTH(WR_DEPTH)) wr_meta (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (wr_push),
    .data_i  (wr_meta_in),
    .pop_i   (wr_pop),
    .data_o  (wr_meta_out),
    .full_o  (wr_full),
    .empty_o (wr_empty)
  );

  // A full FIFO hides the request from the lite side and holds ready low
  // Valid stays stable because the FIFO can only drain while a request waits
  assign mst.aw_addr  = slv.aw_addr;
  assign mst.aw_valid = slv.aw_valid && !wr_full;
  assign slv.aw_ready = mst.aw_ready && !wr_full;

  // The W beat is held back together with AW so both transfer in the same cycle
  assign mst.w_data   = slv.w_data;
  assign mst.w_strb   = slv.w_strb;
  assign mst.w_valid  = slv.w_valid && !wr_full;
  assign slv.w_ready  = mst.w_ready && !wr_full;

  assign mst.ar_addr  = slv.ar_addr;
  assign mst.ar_valid = slv.ar_valid && !rd_full;
  assign slv.ar_ready = mst.ar_ready && !rd_full;

  // Responses get their ID and USER back from the FIFO heads
  // A response is only forwarded while its metadata is present
  assign slv.b_id     = wr_meta_out.id;
  assign slv.b_user   = wr_meta_out.user;
  assign slv.b_resp   = mst.b_resp;
  assign slv.b_valid  = mst.b_valid && !wr_empty;
  assign mst.b_ready  = slv.b_ready;

  assign slv.r_id     = rd_meta_out.id;
  assign slv.r_user   = rd_meta_out.user;
  assign slv.r_data   = mst.r_data;
  assign slv.r_resp   = mst.r_resp;
  assign slv.r_last   = 1'b1;
  assign slv.r_valid  = mst.r_valid && !rd_empty;
  assign mst.r_ready  = slv.r_ready;

endmodule

// File: verilog/axi_lite_regfile.sv
// AXI4-Lite register file
`timescale 1ns/1ns

module axi_lite_regfile import axi_pkg::*; #(
  parameter int NUM_REGS = 16
) (
  input  logic clk_i,
  input  logic rst_i,
  axi_lite_if.slave slv
);

  localparam int IDX_W = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

  // Register storage with one word per entry
  logic [DATA_W-1:0] regs [NUM_REGS];

  // Word addresses drop the two byte offset bits
  logic [ADDR_W-3:0] wr_word;
  logic [ADDR_W-3:0] rd_word;
  logic [IDX_W-1:0]  wr_idx;
  logic [IDX_W-1:0]  rd_idx;
  logic              wr_hit;
  logic              rd_hit;

  logic wr_fire;
  logic rd_fire;

  // Response holding registers
  logic              b_valid_q;
  resp_t             b_resp_q;
  logic              r_valid_q;
  resp_t             r_resp_q;
  logic [DATA_W-1:0] r_data_q;

  assign wr_word = slv.aw_addr[ADDR_W-1:2];
  assign rd_word = slv.ar_addr[ADDR_W-1:2];
  assign wr_idx  = wr_word[IDX_W-1:0];
  assign rd_idx  = rd_word[IDX_W-1:0];

  // Anything past the last register is out of range
  assign wr_hit = wr_word < (ADDR_W-2)'(NUM_REGS);
  assign rd_hit = rd_word < (ADDR_W-2)'(NUM_REGS);

  // A write needs address and data at once and a free B slot
  assign wr_fire     = slv.aw_valid && slv.w_valid && !b_valid_q;
  assign slv.aw_ready = wr_fire;
  assign slv.w_ready  = wr_fire;

  // One read in flight at a time
  assign slv.ar_ready = !r_valid_q;
  assign rd_fire      = slv.ar_valid && !r_valid_q;

  assign slv.b_valid = b_valid_q;
  assign slv.b_resp  = b_resp_q;
  assign slv.r_valid = r_valid_q;
  assign slv.r_resp  = r_resp_q;
  assign slv.r_data  = r_data_q;

  // Byte-wise update of the addressed word
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_fire && wr_hit) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (slv.w_strb[b]) begin
          regs[wr_idx][8*b +: 8] <= slv.w_data[8*b +: 8];
        end
      end
    end
  end

  // Response valid flags are held until the master takes them
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        b_valid_q <= 1'b1;
      end else if (slv.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_fire) begin
        r_valid_q <= 1'b1;
      end else if (slv.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // The response payload is loaded only when a new request is accepted
  // A read of a register written in the same cycle returns the old word
  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      b_resp_q <= wr_hit ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_fire) begin
      r_resp_q <= rd_hit ? RESP_OKAY : RESP_SLVERR;
      r_data_q <= rd_hit ? regs[rd_idx] : '0;
    end
  end

endmodule

// File: verilog/axi_lite_bridge_top.sv
// AXI bridge and register file top
`timescale 1ns/1ns

module axi_lite_bridge_top import axi_pkg::*; #(
  parameter int NUM_PENDING_RD = 2,
  parameter int NUM_PENDING_WR = 2,
  parameter int NUM_REGS       = 16
) (
  input  logic              clk_i,
  input  logic              rst_i,
  // Write address
  input  logic [ID_W-1:0]   aw_id_i,
  input  logic [ADDR_W-1:0] aw_addr_i,
  input  logic [USER_W-1:0] aw_user_i,
  input  logic              aw_valid_i,
  output logic              aw_ready_o,
  // Write data
  input  logic [DATA_W-1:0] w_data_i,
  input  logic [STRB_W-1:0] w_strb_i,
  input  logic              w_valid_i,
  output logic              w_ready_o,
  // Write response
  output logic [ID_W-1:0]   b_id_o,
  output resp_t             b_resp_o,
  output logic [USER_W-1:0] b_user_o,
  output logic              b_valid_o,
  input  logic              b_ready_i,
  // Read address
  input  logic [ID_W-1:0]   ar_id_i,
  input  logic [ADDR_W-1:0] ar_addr_i,
  input  logic [USER_W-1:0] ar_user_i,
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  // Read data
  output logic [ID_W-1:0]   r_id_o,
  output logic [DATA_W-1:0] r_data_o,
  output resp_t             r_resp_o,
  output logic              r_last_o,
  output logic [USER_W-1:0] r_user_o,
  output logic              r_valid_o,
  input  logic              r_ready_i
);

  axi4_if     axi4_bus ();
  axi_lite_if lite_bus ();

  // The ports play the master side of the AXI4 bus
  assign axi4_bus.aw_id    = aw_id_i;
  assign axi4_bus.aw_addr  = aw_addr_i;
  assign axi4_bus.aw_user  = aw_user_i;
  assign axi4_bus.aw_valid = aw_valid_i;
  assign aw_ready_o        = axi4_bus.aw_ready;

  assign axi4_bus.w_data   = w_data_i;
  assign axi4_bus.w_strb   = w_strb_i;
  assign axi4_bus.w_valid  = w_valid_i;
  assign w_ready_o         = axi4_bus.w_ready;

  assign b_id_o            = axi4_bus.b_id;
  assign b_resp_o          = axi4_bus.b_resp;
  assign b_user_o          = axi4_bus.b_user;
  assign b_valid_o         = axi4_bus.b_valid;
  assign axi4_bus.b_ready  = b_ready_i;

  assign axi4_bus.ar_id    = ar_id_i;
  assign axi4_bus.ar_addr  = ar_addr_i;
  assign axi4_bus.ar_user  = ar_user_i;
  assign axi4_bus.ar_valid = ar_valid_i;
  assign ar_ready_o        = axi4_bus.ar_ready;

  assign r_id_o            = axi4_bus.r_id;
  assign r_data_o          = axi4_bus.r_data;
  assign r_resp_o          = axi4_bus.r_resp;
  assign r_last_o          = axi4_bus.r_last;
  assign r_user_o          = axi4_bus.r_user;
  assign r_valid_o         = axi4_bus.r_valid;
  assign axi4_bus.r_ready  = r_ready_i;

  // Protocol conversion with ID and USER reflection
  axi_to_axi_lite #(
    .NUM_PENDING_RD (NUM_PENDING_RD),
    .NUM_PENDING_WR (NUM_PENDING_WR)
  ) axi_to_axi_lite_inst (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .slv   (axi4_bus.slave),
    .mst   (lite_bus.master)
  );

  // Register file behind the lite bus
  axi_lite_regfile #(
    .NUM_REGS (NUM_REGS)
  ) axi_lite_regfile_inst (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .slv   (lite_bus.slave)
  );

endmodule

// File: test/tb_axi_lite_bridge.sv
// AXI4 to AXI4-Lite bridge testbench
`timescale 1ns/1ns

module tb_axi_lite_bridge import axi_pkg::*; ();

  localparam int NUM_REGS   = 16;
  localparam int IDX_W      = $clog2(NUM_REGS);
  localparam int RST_CYCLES = 5;
  localparam int SEED       = 24;
  localparam int MAX_STALL  = 6;
  localparam int NUM_RAND   = 32;
  // Upper bound on the requests issued over all tests
  localparam int TXN_TOTAL  = 8 * NUM_REGS + 4 * NUM_RAND;
  localparam longint WATCHDOG_NS = longint'(TXN_TOTAL * (2 * MAX_STALL + 4) + 200) * 8;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [USER_W-1:0] user;
    resp_t             resp;
  } b_exp_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [USER_W-1:0] user;
    resp_t             resp;
    logic [DATA_W-1:0] data;
  } r_exp_t;

  logic clk_i = 1'b0;
  logic rst_i;
  logic [ID_W-1:0]   aw_id_i, ar_id_i, b_id_o, r_id_o;
  logic [ADDR_W-1:0] aw_addr_i, ar_addr_i;
  logic [USER_W-1:0] aw_user_i, ar_user_i, b_user_o, r_user_o;
  logic [DATA_W-1:0] w_data_i, r_data_o;
  logic [STRB_W-1:0] w_strb_i;
  logic aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, b_valid_o, b_ready_i;
  logic ar_valid_i, ar_ready_o, r_last_o, r_valid_o, r_ready_i;
  resp_t b_resp_o, r_resp_o;

  // Reference register array and the responses still owed by the DUT
  logic [DATA_W-1:0] model_regs [NUM_REGS];
  b_exp_t exp_b_q[$];
  r_exp_t exp_r_q[$];

  string test_name = "none";
  logic  stall_en  = 1'b0;
  int check_cnt, val_errs, other_errs, aw_cnt, b_cnt, ar_cnt, r_cnt;

  // Previous cycle's stalled responses for the stability check
  logic   b_hold, r_hold;
  b_exp_t b_hold_val;
  r_exp_t r_hold_val;

  always #4 clk_i = ~clk_i;

  axi_lite_bridge_top #(
    .NUM_PENDING_RD (2),
    .NUM_PENDING_WR (2),
    .NUM_REGS       (NUM_REGS)
  ) axi_lite_bridge_top_inst (.*);

  function automatic logic in_range(input logic [ADDR_W-1:0] addr);
    return (addr >> 2) < ADDR_W'(NUM_REGS);
  endfunction

  // Strobe bit n selects byte n of the new word
  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                    input logic [DATA_W-1:0] new_word,
                                                    input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] res;
    res = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Returns the expected B of a write and applies the write to the model array
  function automatic b_exp_t model_write(input logic [ADDR_W-1:0] addr,
                                         input logic [DATA_W-1:0] data,
                                         input logic [STRB_W-1:0] strb,
                                         input logic [ID_W-1:0] id,
                                         input logic [USER_W-1:0] user);
    b_exp_t e;
    e.id   = id;
    e.user = user;
    e.resp = in_range(addr) ? RESP_OKAY : RESP_SLVERR;
    if (in_range(addr)) begin
      model_regs[addr[IDX_W+1:2]] = merge_bytes(model_regs[addr[IDX_W+1:2]], data, strb);
    end
    return e;
  endfunction

  // Expected R of a read with zero data outside the register range
  function automatic r_exp_t model_read(input logic [ADDR_W-1:0] addr,
                                        input logic [ID_W-1:0] id,
                                        input logic [USER_W-1:0] user);
    r_exp_t e;
    e.id   = id;
    e.user = user;
    e.resp = in_range(addr) ? RESP_OKAY : RESP_SLVERR;
    e.data = in_range(addr) ? model_regs[addr[IDX_W+1:2]] : '0;
    return e;
  endfunction

  function automatic logic [ADDR_W-1:0] rand_reg_addr();
    return ADDR_W'($urandom_range(NUM_REGS - 1)) << 2;
  endfunction

  // Word addresses past the last register whose low bits alias a real index
  function automatic logic [ADDR_W-1:0] rand_oor_addr();
    return ADDR_W'(NUM_REGS + $urandom_range(1000)) << 2;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    check_cnt++;
    assert (act_v === exp_v) else begin
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
      val_errs++;
    end
  endtask

  // Responses are checked first and the requests taken at this edge are recorded after
  always @(posedge clk_i) begin : compare_responses
    b_exp_t be;
    r_exp_t re;
    if (!rst_i) begin
      if (b_hold) begin
        assert (b_valid_o && b_id_o == b_hold_val.id && b_user_o == b_hold_val.user &&
                b_resp_o == b_hold_val.resp) else begin
          $display("Write response changed or vanished while b_ready was low (%s)", test_name);
          other_errs++;
        end
      end
      if (r_hold) begin
        assert (r_valid_o && r_id_o == r_hold_val.id && r_user_o == r_hold_val.user &&
                r_resp_o == r_hold_val.resp && r_data_o == r_hold_val.data) else begin
          $display("Read response changed or vanished while r_ready was low (%s)", test_name);
          other_errs++;
        end
      end
      b_hold          = b_valid_o && !b_ready_i;
      b_hold_val.id   = b_id_o;
      b_hold_val.user = b_user_o;
      b_hold_val.resp = b_resp_o;
      r_hold          = r_valid_o && !r_ready_i;
      r_hold_val.id   = r_id_o;
      r_hold_val.user = r_user_o;
      r_hold_val.resp = r_resp_o;
      r_hold_val.data = r_data_o;
      if (b_valid_o && b_ready_i) begin
        b_cnt++;
        assert (exp_b_q.size() > 0) else begin
          $display("Write response arrived with no write outstanding (%s)", test_name);
          other_errs++;
        end
        if (exp_b_q.size() > 0) begin
          be = exp_b_q.pop_front();
          check_value("b_id", 32'(be.id), 32'(b_id_o));
          check_value("b_user", 32'(be.user), 32'(b_user_o));
          check_value("b_resp", 32'(be.resp), 32'(b_resp_o));
        end
      end
      if (r_valid_o && r_ready_i) begin
        r_cnt++;
        assert (exp_r_q.size() > 0) else begin
          $display("Read response arrived with no read outstanding (%s)", test_name);
          other_errs++;
        end
        if (exp_r_q.size() > 0) begin
          re = exp_r_q.pop_front();
          check_value("r_id", 32'(re.id), 32'(r_id_o));
          check_value("r_user", 32'(re.user), 32'(r_user_o));
          check_value("r_resp", 32'(re.resp), 32'(r_resp_o));
          check_value("r_data", re.data, r_data_o);
          check_value("r_last", 32'd1, 32'(r_last_o));
        end
      end
      // A read and a write in the same cycle see the old word
      if (ar_valid_i && ar_ready_o) begin
        ar_cnt++;
        exp_r_q.push_back(model_read(ar_addr_i, ar_id_i, ar_user_i));
      end
      if (aw_valid_i && aw_ready_o && w_valid_i && w_ready_o) begin
        aw_cnt++;
        exp_b_q.push_back(model_write(aw_addr_i, w_data_i, w_strb_i, aw_id_i, aw_user_i));
      end
    end
  end

  // Called on a falling edge and returns on the falling edge after the transfer
  task automatic write_txn(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [STRB_W-1:0] strb);
    aw_id_i    = ID_W'($urandom);
    aw_user_i  = USER_W'($urandom);
    aw_addr_i  = addr;
    w_data_i   = data;
    w_strb_i   = strb;
    aw_valid_i = 1'b1;
    w_valid_i  = 1'b1;
    do begin
      @(posedge clk_i);
    end while (!(aw_ready_o && w_ready_o));
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b0;
  endtask

  task automatic read_txn(input logic [ADDR_W-1:0] addr);
    ar_id_i    = ID_W'($urandom);
    ar_user_i  = USER_W'($urandom);
    ar_addr_i  = addr;
    ar_valid_i = 1'b1;
    do begin
      @(posedge clk_i);
    end while (!ar_ready_o);
    @(negedge clk_i);
    ar_valid_i = 1'b0;
  endtask

  // Waits until every issued request has had its response
  task automatic wait_idle();
    while (exp_b_q.size() != 0 || exp_r_q.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  task automatic readback_all();
    for (int i = 0; i < NUM_REGS; i++) begin
      read_txn(ADDR_W'(i) << 2);
    end
    wait_idle();
  endtask

  // Response ready lines toggle after random stretches while stalls are on
  task automatic stretch_ready();
    int b_left;
    int r_left;
    b_left = 0;
    r_left = 0;
    forever begin
      @(negedge clk_i);
      if (!stall_en) begin
        b_ready_i = 1'b1;
        r_ready_i = 1'b1;
      end else begin
        if (b_left == 0) begin
          b_ready_i = ~b_ready_i;
          b_left    = $urandom_range(MAX_STALL, 1);
        end else begin
          b_left--;
        end
        if (r_left == 0) begin
          r_ready_i = ~r_ready_i;
          r_left    = $urandom_range(MAX_STALL, 1);
        end else begin
          r_left--;
        end
      end
    end
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the DUT stopped answering", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main
    rst_i      = 1'b1;
    aw_id_i    = '0;
    aw_addr_i  = '0;
    aw_user_i  = '0;
    aw_valid_i = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_valid_i  = 1'b0;
    b_ready_i  = 1'b1;
    ar_id_i    = '0;
    ar_addr_i  = '0;
    ar_user_i  = '0;
    ar_valid_i = 1'b0;
    r_ready_i  = 1'b1;
    b_hold     = 1'b0;
    r_hold     = 1'b0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    void'($urandom(SEED));
    fork
      stretch_ready();
    join_none
    repeat (RST_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    test_name = "reset";
    assert (!b_valid_o && !r_valid_o) else begin
      $display("A response valid was high right after reset");
      other_errs++;
    end
    readback_all();

    test_name = "full_write";
    repeat (NUM_RAND) write_txn(rand_reg_addr(), DATA_W'($urandom), '1);
    readback_all();

    test_name = "partial_strobe";
    repeat (NUM_RAND) write_txn(rand_reg_addr(), DATA_W'($urandom), STRB_W'($urandom));
    readback_all();

    test_name = "out_of_range";
    repeat (NUM_REGS) write_txn(rand_oor_addr(), DATA_W'($urandom), '1);
    repeat (NUM_REGS) read_txn(rand_oor_addr());
    readback_all();

    // Mixed traffic against stalled response channels
    test_name = "backpressure";
    stall_en  = 1'b1;
    repeat (2 * NUM_RAND) begin
      case ($urandom_range(3))
        0: write_txn(rand_reg_addr(), DATA_W'($urandom), '1);
        1: write_txn(rand_reg_addr(), DATA_W'($urandom), STRB_W'($urandom));
        2: read_txn(rand_reg_addr());
        default: read_txn(rand_oor_addr());
      endcase
    end
    wait_idle();
    stall_en = 1'b0;
    readback_all();

    assert (aw_cnt == b_cnt && ar_cnt == r_cnt) else begin
      $display("Lost or extra responses: %0d writes, %0d B, %0d reads, %0d R",
               aw_cnt, b_cnt, ar_cnt, r_cnt);
      other_errs++;
    end
    $display("Summary: %0d checks, %0d value errors, %0d other errors",
             check_cnt, val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
verilog/axi_pkg.sv
verilog/axi4_if.sv
verilog/axi_lite_if.sv
verilog/id_fifo.sv
verilog/axi_to_axi_lite.sv
verilog/axi_lite_regfile.sv
verilog/axi_lite_bridge_top.sv
test/tb_axi_lite_bridge.sv

// File: Makefile
SIM    ?= verilator
TOP    ?= tb_axi_lite_bridge
FLIST  ?= flist.f
BUILD  ?= obj_dir
LOG    ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with $(SIM), run it and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	elif ! grep -q "TEST OK" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
